//--- exu_core.f
+incdir+testbench
hw/exu_pkg.sv
hw/exu_regfile.sv
hw/exu_bypass.sv
hw/exu_alu.sv
hw/exu_bru.sv
hw/exu.sv
testbench/tb_exu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compiles the exu testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_exu \
   -Mdir obj_dir \
   -f exu_core.f

sim_out=$(./obj_dir/Vtb_exu)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST OK"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation did not pass"
   exit 1
fi

//--- testbench/tb_exu_model.svh
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

// architectural register state as seen by the next instruction to issue
word_t shadow_rf [0:exu_pkg::nregs_c-1];

function automatic void shadow_clear();
   for (int i = 0; i < exu_pkg::nregs_c; i++) begin
      shadow_rf[i] = '0;
   end
endfunction

function automatic word_t shadow_read(input reg_idx_t idx);
   word_t val;
   if (idx == '0) begin
      val = '0;
   end else begin
      val = shadow_rf[idx];
   end
   return val;
endfunction

// r0 never holds anything
function automatic void shadow_write(input reg_idx_t idx, input word_t val);
   if (idx != '0) begin
      shadow_rf[idx] = val;
   end
endfunction

function automatic word_t alu_expect(input alu_op_t op, input word_t a, input word_t b);
   word_t                            r;
   logic [exu_pkg::shamt_bits_c-1:0] sh;
   sh = b[exu_pkg::shamt_bits_c-1:0];
   case (op)
      exu_pkg::alu_add:  r = a + b;
      exu_pkg::alu_sub:  r = a - b;
      exu_pkg::alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exu_pkg::alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
      exu_pkg::alu_and:  r = a & b;
      exu_pkg::alu_or:   r = a | b;
      exu_pkg::alu_nor:  r = ~(a | b);
      exu_pkg::alu_xor:  r = a ^ b;
      exu_pkg::alu_sll:  r = a << sh;
      exu_pkg::alu_srl:  r = a >> sh;
      exu_pkg::alu_sra: begin
         // logical shift, then refill the vacated top bits with the sign
         r = a >> sh;
         if (a[exu_pkg::xlen_c-1]) begin
            r = r | ~(32'hffff_ffff >> sh);
         end
      end
      exu_pkg::alu_lui:  r = b;
      default:           r = '0;
   endcase
   return r;
endfunction

function automatic logic branch_expect(input bru_op_t op, input word_t a, input word_t b);
   logic t;
   case (op)
      exu_pkg::bru_beq:  t = (a == b);
      exu_pkg::bru_bne:  t = (a != b);
      exu_pkg::bru_blt:  t = ($signed(a) < $signed(b));
      exu_pkg::bru_bge:  t = ($signed(a) >= $signed(b));
      exu_pkg::bru_bltu: t = (a < b);
      exu_pkg::bru_bgeu: t = (a >= b);
      exu_pkg::bru_b,
      exu_pkg::bru_bl,
      exu_pkg::bru_jirl: t = 1'b1;
      default:           t = 1'b0;
   endcase
   return t;
endfunction

function automatic word_t target_expect(input bru_op_t op, input word_t a, input word_t pc,
                                        input word_t offset);
   word_t t;
   if (op == exu_pkg::bru_jirl) begin
      t = a + offset;
   end else begin
      t = pc + offset;
   end
   return t;
endfunction

`endif

//--- testbench/tb_exu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu;

   typedef exu_pkg::word_t    word_t;
   typedef exu_pkg::reg_idx_t reg_idx_t;
   typedef exu_pkg::alu_op_t  alu_op_t;
   typedef exu_pkg::bru_op_t  bru_op_t;

   // what the w stage should show for one issued instruction
   typedef struct packed {
      int       tag;
      word_t    pc;
      logic     wen;
      reg_idx_t rd;
      word_t    data;
      logic     taken;
      word_t    target;
   } exp_t;

   logic     clk;
   logic     rst_n;
   logic     ifu_exu_vld_d;
   word_t    ifu_exu_pc_d;
   reg_idx_t ifu_exu_rs1_d;
   reg_idx_t ifu_exu_rs2_d;
   reg_idx_t ifu_exu_rd_d;
   logic     ifu_exu_wen_d;
   word_t    ifu_exu_imm_d;
   logic     ifu_exu_alu_vld_d;
   alu_op_t  ifu_exu_alu_op_d;
   logic     ifu_exu_alu_a_pc_d;
   logic     ifu_exu_alu_b_imm_d;
   logic     ifu_exu_bru_vld_d;
   bru_op_t  ifu_exu_bru_op_d;
   word_t    ifu_exu_bru_offset_d;
   logic     exu_ifu_branch;
   word_t    exu_ifu_brn_addr;
   word_t    debug_wb_pc;
   logic     debug_wb_rf_wen;
   reg_idx_t debug_wb_rf_wnum;
   word_t    debug_wb_rf_wdata;

   exp_t  exp_q[$];
   int    cycle = 0;
   int    errors = 0;
   int    checks = 0;
   int    tests = 0;
   bit    checking = 1'b0;
   word_t pc_next = 32'h1c00_0000;

   `include "tb_exu_model.svh"

   exu exu_i (
      .clk                  (clk),
      .rst_n                (rst_n),
      .ifu_exu_vld_d        (ifu_exu_vld_d),
      .ifu_exu_pc_d         (ifu_exu_pc_d),
      .ifu_exu_rs1_d        (ifu_exu_rs1_d),
      .ifu_exu_rs2_d        (ifu_exu_rs2_d),
      .ifu_exu_rd_d         (ifu_exu_rd_d),
      .ifu_exu_wen_d        (ifu_exu_wen_d),
      .ifu_exu_imm_d        (ifu_exu_imm_d),
      .ifu_exu_alu_vld_d    (ifu_exu_alu_vld_d),
      .ifu_exu_alu_op_d     (ifu_exu_alu_op_d),
      .ifu_exu_alu_a_pc_d   (ifu_exu_alu_a_pc_d),
      .ifu_exu_alu_b_imm_d  (ifu_exu_alu_b_imm_d),
      .ifu_exu_bru_vld_d    (ifu_exu_bru_vld_d),
      .ifu_exu_bru_op_d     (ifu_exu_bru_op_d),
      .ifu_exu_bru_offset_d (ifu_exu_bru_offset_d),
      .exu_ifu_branch       (exu_ifu_branch),
      .exu_ifu_brn_addr     (exu_ifu_brn_addr),
      .debug_wb_pc          (debug_wb_pc),
      .debug_wb_rf_wen      (debug_wb_rf_wen),
      .debug_wb_rf_wnum     (debug_wb_rf_wnum),
      .debug_wb_rf_wdata    (debug_wb_rf_wdata)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10;
         clk = ~clk;
      end
   end

   // rising edge count, the tag space of the expected queue
   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   task automatic report_mismatch(input string msg);
      errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic check_entry(input exp_t e);
      checks++;
      if (debug_wb_rf_wen !== e.wen) begin
         report_mismatch($sformatf("pc %08h: commit enable %b, expected %b",
                                   e.pc, debug_wb_rf_wen, e.wen));
      end else if (e.wen) begin
         if (debug_wb_rf_wnum !== e.rd) begin
            report_mismatch($sformatf("pc %08h: rd %0d, expected %0d",
                                      e.pc, debug_wb_rf_wnum, e.rd));
         end
         if (debug_wb_rf_wdata !== e.data) begin
            report_mismatch($sformatf("pc %08h: wdata %08h, expected %08h",
                                      e.pc, debug_wb_rf_wdata, e.data));
         end
         if (debug_wb_pc !== e.pc) begin
            report_mismatch($sformatf("commit pc %08h, expected %08h", debug_wb_pc, e.pc));
         end
      end
      if (exu_ifu_branch !== e.taken) begin
         report_mismatch($sformatf("pc %08h: branch %b, expected %b",
                                   e.pc, exu_ifu_branch, e.taken));
      end else if (e.taken && (exu_ifu_brn_addr !== e.target)) begin
         report_mismatch($sformatf("pc %08h: target %08h, expected %08h",
                                   e.pc, exu_ifu_brn_addr, e.target));
      end
   endtask

   // nothing valid in w
   task automatic check_quiet();
      checks++;
      if (debug_wb_rf_wen !== 1'b0) begin
         report_mismatch("commit enable high with no instruction in w");
      end
      if (exu_ifu_branch !== 1'b0) begin
         report_mismatch("branch pulse with no instruction in w");
      end
   endtask

   // outputs only move on the rising edge, so the falling edge is a safe sample point
   initial begin : compare_proc
      exp_t e;
      forever begin
         @(negedge clk);
         if (checking) begin
            while ((exp_q.size() != 0) && (exp_q[0].tag < cycle - 2)) begin
               e = exp_q.pop_front();
               errors++;
               $display("instruction at pc %08h was never compared", e.pc);
            end
            if ((exp_q.size() != 0) && (exp_q[0].tag == cycle - 2)) begin
               e = exp_q.pop_front();
               check_entry(e);
            end else begin
               check_quiet();
            end
         end
      end
   end

   task automatic bubble(input int n);
      repeat (n) begin
         @(negedge clk);
         ifu_exu_vld_d     = 1'b0;
         ifu_exu_alu_vld_d = 1'b0;
         ifu_exu_bru_vld_d = 1'b0;
      end
   endtask

   // drive one instruction and record its expected retirement
   task automatic send(
      input bit       is_alu,
      input alu_op_t  aop,
      input bru_op_t  bop,
      input reg_idx_t rd,
      input reg_idx_t rs1,
      input reg_idx_t rs2,
      input logic     wen,
      input word_t    imm,
      input logic     a_pc,
      input logic     b_imm,
      input word_t    offset
   );
      exp_t  e;
      word_t ra;
      word_t rb;
      @(negedge clk);
      ifu_exu_vld_d        = 1'b1;
      ifu_exu_pc_d         = pc_next;
      ifu_exu_rs1_d        = rs1;
      ifu_exu_rs2_d        = rs2;
      ifu_exu_rd_d         = rd;
      ifu_exu_wen_d        = wen;
      ifu_exu_imm_d        = imm;
      ifu_exu_alu_vld_d    = is_alu;
      ifu_exu_alu_op_d     = aop;
      ifu_exu_alu_a_pc_d   = a_pc;
      ifu_exu_alu_b_imm_d  = b_imm;
      ifu_exu_bru_vld_d    = !is_alu;
      ifu_exu_bru_op_d     = bop;
      ifu_exu_bru_offset_d = offset;
      ra       = shadow_read(rs1);
      rb       = shadow_read(rs2);
      e.tag    = cycle + 1;
      e.pc     = pc_next;
      e.rd     = rd;
      e.wen    = wen && (rd != '0);
      e.taken  = 1'b0;
      e.target = '0;
      if (is_alu) begin
         e.data = alu_expect(aop, a_pc ? pc_next : ra, b_imm ? imm : rb);
      end else begin
         e.data   = pc_next + exu_pkg::inst_bytes_c;
         e.taken  = branch_expect(bop, ra, rb);
         e.target = target_expect(bop, ra, pc_next, offset);
      end
      if (e.wen) begin
         shadow_write(rd, e.data);
      end
      exp_q.push_back(e);
      pc_next = pc_next + exu_pkg::inst_bytes_c;
   endtask

   task automatic alu_rr(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                         input reg_idx_t rs2);
      send(1'b1, op, exu_pkg::bru_beq, rd, rs1, rs2, 1'b1, '0, 1'b0, 1'b0, '0);
   endtask

   task automatic alu_ri(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                         input word_t imm);
      send(1'b1, op, exu_pkg::bru_beq, rd, rs1, 0, 1'b1, imm, 1'b0, 1'b1, '0);
   endtask

   task automatic load_imm(input reg_idx_t rd, input word_t val);
      alu_ri(exu_pkg::alu_lui, rd, 0, val);
   endtask

   task automatic branch(input bru_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                         input reg_idx_t rs2, input word_t offset, input logic wen);
      send(1'b0, exu_pkg::alu_add, op, rd, rs1, rs2, wen, '0, 1'b0, 1'b0, offset);
   endtask

   // let every issued instruction reach the compare process
   task automatic drain_pipeline();
      int waited;
      waited = 0;
      bubble(1);
      while ((exp_q.size() != 0) && (waited < 10)) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("timed out waiting for %0d instructions to retire", exp_q.size());
         exp_q.delete();
      end
   endtask

   task automatic close_test(input string name, input int mark);
      drain_pipeline();
      tests++;
      $display("%-24s %0d errors", name, errors - mark);
   endtask

   task automatic idle_after_reset();
      int mark;
      mark = errors;
      bubble(20);
      close_test("idle after reset", mark);
   endtask

   task automatic alu_op_sweep();
      int mark;
      mark = errors;
      for (int k = 0; k < 12; k++) begin
         load_imm(1, $urandom);
         load_imm(2, $urandom);
         alu_rr(alu_op_t'(k[3:0]), 3, 1, 2);
         alu_ri(alu_op_t'(k[3:0]), 4, 1, $urandom);
      end
      close_test("alu ops", mark);
   endtask

   task automatic forwarding_distances();
      int mark;
      mark = errors;
      for (int d = 1; d <= 3; d++) begin
         load_imm(5, $urandom);
         bubble(d - 1);
         alu_rr(exu_pkg::alu_add, 6, 5, 5);
         alu_rr(exu_pkg::alu_xor, 6, 6, 5);
         bubble(d - 1);
         alu_rr(exu_pkg::alu_sub, 7, 0, 6);
      end
      // m and w both hold r5, the younger value must win
      load_imm(5, $urandom);
      load_imm(5, $urandom);
      alu_rr(exu_pkg::alu_or, 8, 5, 0);
      close_test("forwarding", mark);
   endtask

   task automatic branch_case(input bru_op_t op, input bit want);
      word_t a;
      word_t b;
      int    tries;
      a     = $urandom;
      b     = a;
      tries = 0;
      while ((branch_expect(op, a, b) != want) && (tries < 64)) begin
         a = $urandom;
         case ($urandom % 3)
            0:       b = a;
            1:       b = a + 1;
            default: b = $urandom;
         endcase
         tries++;
      end
      if (branch_expect(op, a, b) != want) begin
         errors++;
         $display("no operand pair found for branch op %0d", op);
      end
      // operands straight from the two loads before
      load_imm(7, a);
      load_imm(8, b);
      branch(op, 0, 7, 8, $urandom & 32'hffff_fffc, 1'b0);
   endtask

   task automatic branch_conditions();
      int mark;
      mark = errors;
      for (int k = 0; k < 6; k++) begin
         branch_case(bru_op_t'(k[3:0]), 1'b1);
         branch_case(bru_op_t'(k[3:0]), 1'b0);
      end
      branch(exu_pkg::bru_b, 0, 0, 0, $urandom & 32'hffff_fffc, 1'b0);
      branch(exu_pkg::bru_bl, 9, 0, 0, $urandom & 32'hffff_fffc, 1'b1);
      load_imm(7, $urandom & 32'hffff_fffc);
      branch(exu_pkg::bru_jirl, 10, 7, 0, $urandom & 32'h0000_fffc, 1'b1);
      alu_rr(exu_pkg::alu_add, 11, 9, 10);
      close_test("branches", mark);
   endtask

   task automatic r0_and_pc_operands();
      int mark;
      mark = errors;
      load_imm(11, $urandom);
      send(1'b1, exu_pkg::alu_add, exu_pkg::bru_beq, 0, 11, 11, 1'b1, '0, 1'b0, 1'b0, '0);
      send(1'b1, exu_pkg::alu_lui, exu_pkg::bru_beq, 11, 0, 0, 1'b0, $urandom,
           1'b0, 1'b1, '0);
      alu_rr(exu_pkg::alu_or, 12, 0, 0);
      alu_rr(exu_pkg::alu_add, 13, 11, 0);
      send(1'b1, exu_pkg::alu_add, exu_pkg::bru_beq, 14, 0, 0, 1'b1, $urandom,
           1'b1, 1'b1, '0);
      send(1'b1, exu_pkg::alu_add, exu_pkg::bru_beq, 15, 0, 11, 1'b1, '0, 1'b1, 1'b0, '0);
      close_test("r0 and pc operands", mark);
   endtask

   task automatic random_stream();
      int       mark;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      bru_op_t  bop;
      mark = errors;
      for (int n = 0; n < 300; n++) begin
         if (($urandom % 4) == 0) begin
            bubble(1 + ($urandom % 2));
         end
         // few registers so that most instructions depend on a recent one
         rd  = reg_idx_t'($urandom % 8);
         rs1 = reg_idx_t'($urandom % 8);
         rs2 = reg_idx_t'($urandom % 8);
         if (($urandom % 4) == 0) begin
            bop = bru_op_t'($urandom % 9);
            branch(bop, rd, rs1, rs2, $urandom & 32'hffff_fffc,
                   (bop == exu_pkg::bru_bl) || (bop == exu_pkg::bru_jirl));
         end else begin
            send(1'b1, alu_op_t'($urandom % 12), exu_pkg::bru_beq, rd, rs1, rs2,
                 ($urandom % 8) != 0, $urandom, ($urandom % 8) == 0, ($urandom % 2) == 0,
                 '0);
         end
      end
      close_test("random stream", mark);
   endtask

   initial begin : main_proc
      void'($urandom(32'hfd35));
      rst_n                = 1'b0;
      ifu_exu_vld_d        = 1'b0;
      ifu_exu_pc_d         = '0;
      ifu_exu_rs1_d        = '0;
      ifu_exu_rs2_d        = '0;
      ifu_exu_rd_d         = '0;
      ifu_exu_wen_d        = 1'b0;
      ifu_exu_imm_d        = '0;
      ifu_exu_alu_vld_d    = 1'b0;
      ifu_exu_alu_op_d     = exu_pkg::alu_add;
      ifu_exu_alu_a_pc_d   = 1'b0;
      ifu_exu_alu_b_imm_d  = 1'b0;
      ifu_exu_bru_vld_d    = 1'b0;
      ifu_exu_bru_op_d     = exu_pkg::bru_beq;
      ifu_exu_bru_offset_d = '0;
      shadow_clear();
      repeat (10) begin
         @(negedge clk);
      end
      rst_n    = 1'b1;
      checking = 1'b1;

      idle_after_reset();
      alu_op_sweep();
      forwarding_distances();
      branch_conditions();
      r0_and_pc_operands();
      random_stream();

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
   input  logic              clk,
   input  logic              rst_n,

   input  logic              ifu_exu_vld_d,
   input  exu_pkg::word_t    ifu_exu_pc_d,
   input  exu_pkg::reg_idx_t ifu_exu_rs1_d,
   input  exu_pkg::reg_idx_t ifu_exu_rs2_d,
   input  exu_pkg::reg_idx_t ifu_exu_rd_d,
   input  logic              ifu_exu_wen_d,
   input  exu_pkg::word_t    ifu_exu_imm_d,

   input  logic              ifu_exu_alu_vld_d,
   input  exu_pkg::alu_op_t  ifu_exu_alu_op_d,
   input  logic              ifu_exu_alu_a_pc_d,
   input  logic              ifu_exu_alu_b_imm_d,

   input  logic              ifu_exu_bru_vld_d,
   input  exu_pkg::bru_op_t  ifu_exu_bru_op_d,
   input  exu_pkg::word_t    ifu_exu_bru_offset_d,

   output logic              exu_ifu_branch,
   output exu_pkg::word_t    exu_ifu_brn_addr,

   // commit trace
   output exu_pkg::word_t    debug_wb_pc,
   output logic              debug_wb_rf_wen,
   output exu_pkg::reg_idx_t debug_wb_rf_wnum,
   output exu_pkg::word_t    debug_wb_rf_wdata
);

   exu_pkg::word_t    rs1_data_d;
   exu_pkg::word_t    rs2_data_d;

   // e stage
   logic              alu_vld_e;
   logic              bru_vld_e;
   logic              wen_e;
   exu_pkg::word_t    pc_e;
   exu_pkg::reg_idx_t rs1_e;
   exu_pkg::reg_idx_t rs2_e;
   exu_pkg::reg_idx_t rd_e;
   exu_pkg::word_t    rs1_data_e;
   exu_pkg::word_t    rs2_data_e;
   exu_pkg::word_t    imm_e;
   exu_pkg::alu_op_t  alu_op_e;
   logic              alu_a_pc_e;
   logic              alu_b_imm_e;
   exu_pkg::bru_op_t  bru_op_e;
   exu_pkg::word_t    bru_offset_e;

   exu_pkg::word_t    rs1_data_byp_e;
   exu_pkg::word_t    rs2_data_byp_e;
   exu_pkg::word_t    alu_a_e;
   exu_pkg::word_t    alu_b_e;
   exu_pkg::word_t    alu_res_e;
   logic              bru_branch_e;
   exu_pkg::word_t    bru_brn_addr_e;
   exu_pkg::word_t    bru_link_pc_e;

   // m stage
   logic              alu_vld_m;
   logic              bru_vld_m;
   logic              wen_m;
   exu_pkg::word_t    pc_m;
   exu_pkg::reg_idx_t rd_m;
   exu_pkg::word_t    alu_res_m;
   exu_pkg::word_t    bru_link_pc_m;
   logic              bru_branch_m;
   exu_pkg::word_t    bru_brn_addr_m;
   exu_pkg::word_t    rd_data_m;

   // w stage
   logic              wen_w;
   exu_pkg::word_t    pc_w;
   exu_pkg::reg_idx_t rd_w;
   exu_pkg::word_t    rd_data_w;
   logic              bru_branch_w;
   exu_pkg::word_t    bru_brn_addr_w;

   exu_regfile u_rf (
      .clk    (clk),
      .rst_n  (rst_n),
      .raddr0 (ifu_exu_rs1_d),
      .raddr1 (ifu_exu_rs2_d),
      .wen    (wen_w),
      .waddr  (rd_w),
      .wdata  (rd_data_w),
      .rdata0 (rs1_data_d),
      .rdata1 (rs2_data_d)
   );

   exu_bypass u_byp (
      .rs1_e          (rs1_e),
      .rs2_e          (rs2_e),
      .rs1_data_e     (rs1_data_e),
      .rs2_data_e     (rs2_data_e),
      .rd_m           (rd_m),
      .rd_w           (rd_w),
      .wen_m          (wen_m),
      .wen_w          (wen_w),
      .rd_data_m      (rd_data_m),
      .rd_data_w      (rd_data_w),
      .rs1_data_byp_e (rs1_data_byp_e),
      .rs2_data_byp_e (rs2_data_byp_e)
   );

   assign alu_a_e = alu_a_pc_e  ? pc_e  : rs1_data_byp_e;
   assign alu_b_e = alu_b_imm_e ? imm_e : rs2_data_byp_e;

   exu_alu u_alu (
      .a   (alu_a_e),
      .b   (alu_b_e),
      .op  (alu_op_e),
      .res (alu_res_e)
   );

   exu_bru u_bru (
      .vld     (bru_vld_e),
      .op      (bru_op_e),
      .a       (rs1_data_byp_e),
      .b       (rs2_data_byp_e),
      .pc      (pc_e),
      .offset  (bru_offset_e),
      .taken   (bru_branch_e),
      .target  (bru_brn_addr_e),
      .link_pc (bru_link_pc_e)
   );

   // unit valids are one-hot, so an and-or mux is enough
   assign rd_data_m = ({exu_pkg::xlen_c{alu_vld_m}} & alu_res_m) |
                      ({exu_pkg::xlen_c{bru_vld_m}} & bru_link_pc_m);

   // valid and enable bits, a bubble when d is not valid
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_vld_e    <= 1'b0;
         bru_vld_e    <= 1'b0;
         wen_e        <= 1'b0;
         alu_vld_m    <= 1'b0;
         bru_vld_m    <= 1'b0;
         wen_m        <= 1'b0;
         bru_branch_m <= 1'b0;
         wen_w        <= 1'b0;
         bru_branch_w <= 1'b0;
      end else begin
         alu_vld_e    <= ifu_exu_vld_d & ifu_exu_alu_vld_d;
         bru_vld_e    <= ifu_exu_vld_d & ifu_exu_bru_vld_d;
         wen_e        <= ifu_exu_vld_d & ifu_exu_wen_d & (ifu_exu_rd_d != '0);
         alu_vld_m    <= alu_vld_e;
         bru_vld_m    <= bru_vld_e;
         wen_m        <= wen_e;
         bru_branch_m <= bru_branch_e;
         wen_w        <= wen_m;
         bru_branch_w <= bru_branch_m;
      end
   end

   // instruction fields only move on a valid instruction
   always_ff @(posedge clk) begin
      if (ifu_exu_vld_d) begin
         pc_e         <= ifu_exu_pc_d;
         rs1_e        <= ifu_exu_rs1_d;
         rs2_e        <= ifu_exu_rs2_d;
         rd_e         <= ifu_exu_rd_d;
         rs1_data_e   <= rs1_data_d;
         rs2_data_e   <= rs2_data_d;
         imm_e        <= ifu_exu_imm_d;
         alu_op_e     <= ifu_exu_alu_op_d;
         alu_a_pc_e   <= ifu_exu_alu_a_pc_d;
         alu_b_imm_e  <= ifu_exu_alu_b_imm_d;
         bru_op_e     <= ifu_exu_bru_op_d;
         bru_offset_e <= ifu_exu_bru_offset_d;
      end
   end

   // m and w payload
   always_ff @(posedge clk) begin
      pc_m           <= pc_e;
      rd_m           <= rd_e;
      alu_res_m      <= alu_res_e;
      bru_link_pc_m  <= bru_link_pc_e;
      bru_brn_addr_m <= bru_brn_addr_e;
      pc_w           <= pc_m;
      rd_w           <= rd_m;
      rd_data_w      <= rd_data_m;
      bru_brn_addr_w <= bru_brn_addr_m;
   end

   assign exu_ifu_branch   = bru_branch_w;
   assign exu_ifu_brn_addr = bru_brn_addr_w;

   assign debug_wb_pc       = pc_w;
   assign debug_wb_rf_wen   = wen_w;
   assign debug_wb_rf_wnum  = rd_w;
   assign debug_wb_rf_wdata = rd_data_w;

   // decode issues each instruction to a single unit
   a_one_unit_e: assert property (@(posedge clk) disable iff (!rst_n)
      !(alu_vld_e && bru_vld_e));

endmodule

`default_nettype wire

//--- hw/exu_bru.sv
`timescale 1ns/1ps
`default_nettype none

module exu_bru (
   input  logic             vld,
   input  exu_pkg::bru_op_t op,
   input  exu_pkg::word_t   a,
   input  exu_pkg::word_t   b,
   input  exu_pkg::word_t   pc,
   input  exu_pkg::word_t   offset,
   output logic             taken,
   output exu_pkg::word_t   target,
   output exu_pkg::word_t   link_pc
);

   logic           eq;
   logic           lt_s;
   logic           lt_u;
   logic           cond;
   exu_pkg::word_t base;

   // compares on the forwarded operands
   assign eq   = (a == b);
   assign lt_s = ($signed(a) < $signed(b));
   assign lt_u = (a < b);

   always_comb begin
      unique case (op)
         exu_pkg::bru_beq: begin
            cond = eq;
         end
         exu_pkg::bru_bne: begin
            cond = ~eq;
         end
         exu_pkg::bru_blt: begin
            cond = lt_s;
         end
         exu_pkg::bru_bge: begin
            cond = ~lt_s;
         end
         exu_pkg::bru_bltu: begin
            cond = lt_u;
         end
         exu_pkg::bru_bgeu: begin
            cond = ~lt_u;
         end
         exu_pkg::bru_b,
         exu_pkg::bru_bl,
         exu_pkg::bru_jirl: begin
            cond = 1'b1;
         end
         default: begin
            cond = 1'b0;
         end
      endcase
   end

   assign taken = vld & cond;

   // jirl is register relative, everything else pc relative
   assign base    = (op == exu_pkg::bru_jirl) ? a : pc;
   assign target  = base + offset;
   assign link_pc = pc + exu_pkg::inst_bytes_c;

endmodule

`default_nettype wire

//--- hw/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
   input  exu_pkg::word_t  a,
   input  exu_pkg::word_t  b,
   input  exu_pkg::alu_op_t op,
   output exu_pkg::word_t  res
);

   logic                             sub;
   exu_pkg::word_t                   b_adj;
   exu_pkg::word_t                   sum;
   logic                             carry;
   logic                             lt_s;
   logic                             lt_u;
   logic [exu_pkg::shamt_bits_c-1:0] shamt;

   // one adder shared by add, sub and both compares
   assign sub = (op == exu_pkg::alu_sub) ||
                (op == exu_pkg::alu_slt) ||
                (op == exu_pkg::alu_sltu);

   assign b_adj = sub ? ~b : b;

   assign {carry, sum} = {1'b0, a} + {1'b0, b_adj} + {{exu_pkg::xlen_c{1'b0}}, sub};

   // signs differ: a is less when it is negative
   // signs equal: look at the difference
   assign lt_s = (a[exu_pkg::xlen_c-1] & ~b[exu_pkg::xlen_c-1]) |
                 (~(a[exu_pkg::xlen_c-1] ^ b[exu_pkg::xlen_c-1]) & sum[exu_pkg::xlen_c-1]);

   // no carry out of a - b means a borrow
   assign lt_u = ~carry;

   assign shamt = b[exu_pkg::shamt_bits_c-1:0];

   always_comb begin
      unique case (op)
         exu_pkg::alu_add,
         exu_pkg::alu_sub: begin
            res = sum;
         end
         exu_pkg::alu_slt: begin
            res = {{(exu_pkg::xlen_c-1){1'b0}}, lt_s};
         end
         exu_pkg::alu_sltu: begin
            res = {{(exu_pkg::xlen_c-1){1'b0}}, lt_u};
         end
         exu_pkg::alu_and: begin
            res = a & b;
         end
         exu_pkg::alu_or: begin
            res = a | b;
         end
         exu_pkg::alu_nor: begin
            res = ~(a | b);
         end
         exu_pkg::alu_xor: begin
            res = a ^ b;
         end
         exu_pkg::alu_sll: begin
            res = a << shamt;
         end
         exu_pkg::alu_srl: begin
            res = a >> shamt;
         end
         exu_pkg::alu_sra: begin
            res = $signed(a) >>> shamt;
         end
         exu_pkg::alu_lui: begin
            res = b;
         end
         default: begin
            res = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hw/exu_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module exu_bypass (
   input  exu_pkg::reg_idx_t rs1_e,
   input  exu_pkg::reg_idx_t rs2_e,
   input  exu_pkg::word_t    rs1_data_e,
   input  exu_pkg::word_t    rs2_data_e,
   input  exu_pkg::reg_idx_t rd_m,
   input  exu_pkg::reg_idx_t rd_w,
   input  logic              wen_m,
   input  logic              wen_w,
   input  exu_pkg::word_t    rd_data_m,
   input  exu_pkg::word_t    rd_data_w,
   output exu_pkg::word_t    rs1_data_byp_e,
   output exu_pkg::word_t    rs2_data_byp_e
);

   // youngest producer wins: m before w before the register file
   function automatic exu_pkg::word_t forward(
      input exu_pkg::reg_idx_t rs,
      input exu_pkg::word_t    rf_data
   );
      exu_pkg::word_t val;
      if (wen_m && (rd_m == rs)) begin
         val = rd_data_m;
      end else if (wen_w && (rd_w == rs)) begin
         val = rd_data_w;
      end else begin
         val = rf_data;
      end
      return val;
   endfunction

   // enables are already clear for r0 destinations
   always_comb begin
      rs1_data_byp_e = forward(rs1_e, rs1_data_e);
      rs2_data_byp_e = forward(rs2_e, rs2_data_e);
   end

endmodule

`default_nettype wire

//--- hw/exu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module exu_regfile (
   input  logic              clk,
   input  logic              rst_n,
   input  exu_pkg::reg_idx_t raddr0,
   input  exu_pkg::reg_idx_t raddr1,
   input  logic              wen,
   input  exu_pkg::reg_idx_t waddr,
   input  exu_pkg::word_t    wdata,
   output exu_pkg::word_t    rdata0,
   output exu_pkg::word_t    rdata1
);

   // r0 has no storage
   exu_pkg::word_t regs [1:exu_pkg::nregs_c-1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < exu_pkg::nregs_c; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // write-through so a reader in d sees the value retiring from w
   function automatic exu_pkg::word_t read_port(input exu_pkg::reg_idx_t addr);
      exu_pkg::word_t val;
      if (addr == '0) begin
         val = '0;
      end else if (wen && (addr == waddr)) begin
         val = wdata;
      end else begin
         val = regs[addr];
      end
      return val;
   endfunction

   always_comb begin
      rdata0 = read_port(raddr0);
      rdata1 = read_port(raddr1);
   end

   // the pipeline drops the enable for rd == 0 before it gets here
   a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
      wen |-> (waddr != '0));

endmodule

`default_nettype wire

//--- hw/exu_pkg.sv
`default_nettype none

package exu_pkg;

   // datapath width
   localparam int unsigned xlen_c = 32;

   typedef logic [xlen_c-1:0] word_t;

   // integer register file geometry
   localparam int unsigned nregs_c = 32;

   typedef logic [$clog2(nregs_c)-1:0] reg_idx_t;

   // shift amount taken from the low bits of operand b
   localparam int unsigned shamt_bits_c = 5;

   // fixed instruction size, used for the link address
   localparam word_t inst_bytes_c = 32'd4;

   // alu op codes, 4 bits as driven by decode
   typedef enum logic [3:0] {
      alu_add  = 4'h0,
      alu_sub  = 4'h1,
      alu_slt  = 4'h2,
      alu_sltu = 4'h3,
      alu_and  = 4'h4,
      alu_or   = 4'h5,
      alu_nor  = 4'h6,
      alu_xor  = 4'h7,
      alu_sll  = 4'h8,
      alu_srl  = 4'h9,
      alu_sra  = 4'ha,
      alu_lui  = 4'hb  // passes operand b
   } alu_op_t;

   // branch op codes
   typedef enum logic [3:0] {
      bru_beq  = 4'h0,
      bru_bne  = 4'h1,
      bru_blt  = 4'h2,
      bru_bge  = 4'h3,
      bru_bltu = 4'h4,
      bru_bgeu = 4'h5,
      bru_b    = 4'h6,
      bru_bl   = 4'h7,
      bru_jirl = 4'h8
   } bru_op_t;

endpackage

`default_nettype wire
